// File: aes_requestor/line_fifo.sv
// Line FIFO, a first-word fall-through circular buffer of read response lines.
`timescale 1ns/1ps
`default_nettype none

module line_fifo
  import aes_stream_pkg::*;
#(
  parameter int DEPTH = 16
)
(
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               push,
  input  wire t_line              push_line,
  input  wire logic               pop,
  output t_line                   pop_line,
  output logic                    not_full,
  output logic                    not_empty,
  output logic [$clog2(DEPTH):0]  count
);

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = PTR_BITS + 1;

  t_line mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_line;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  // the head entry is visible before it is popped.
  assign pop_line  = mem[rd_ptr];
  assign not_full  = (count != CNT_BITS'(DEPTH));
  assign not_empty = (count != '0);

  a_no_overflow : assert property (@(posedge clk) disable iff (reset) push |-> not_full);
  a_no_underflow : assert property (@(posedge clk) disable iff (reset) pop |-> not_empty);

endmodule : line_fifo

`default_nettype wire

// File: aes_requestor/read_requestor.sv
// Read requestor, which fetches the key and source lines and splits each line into blocks.
`timescale 1ns/1ps
`default_nettype none
`include "aes_stream_config.svh"

module read_requestor
  import aes_stream_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      start,
  input  wire t_addr                     key_addr,
  input  wire t_addr                     src_addr,
  input  wire logic [`AES_ADDR_BITS-1:0] num_lines,
  output logic                           rd_req_valid,
  output t_addr                          rd_req_addr,
  input  wire logic                      rd_almost_full,
  input  wire logic                      rd_rsp_valid,
  input  wire t_line                     rd_rsp_data,
  output t_block                         key,
  output logic                           key_valid,
  block_stream_if.source                 blocks
);

  localparam int DEPTH       = `AES_FIFO_DEPTH;
  localparam int CREDIT_BITS = $clog2(DEPTH) + 1;
  localparam int BLOCK_BITS  = `AES_BLOCK_BITS;

  t_rd_state rd_state;
  t_rd_state rd_next_state;

  t_addr rd_count;
  t_line push_line;
  t_line pop_line;
  t_line line_hold;

  logic push;
  logic pop;
  logic fifo_not_full;
  logic fifo_not_empty;
  logic key_issue;
  logic src_issue;
  logic split_active;
  logic [1:0] split_idx;
  logic [`AES_ADDR_BITS-1:0] split_count;
  logic [CREDIT_BITS-1:0] in_flight;
  logic [CREDIT_BITS-1:0] fifo_count;
  logic [CREDIT_BITS:0] credits;

  line_fifo #(
    .DEPTH (DEPTH)
  ) i_line_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_line (push_line),
    .pop       (pop),
    .pop_line  (pop_line),
    .not_full  (fifo_not_full),
    .not_empty (fifo_not_empty),
    .count     (fifo_count)
  );

  // a credit is held from the source read until its line leaves the FIFO.
  assign credits   = in_flight + fifo_count;
  assign key_issue = !rd_almost_full &&
                     (((rd_state == rd_idle) && start) || (rd_state == rd_fetch_key));
  assign src_issue = (rd_state == rd_fetch) && key_valid && !rd_almost_full &&
                     (credits < DEPTH);
  assign pop       = fifo_not_empty && !split_active && !blocks.stall;

  always_comb begin
    rd_next_state = rd_state;
    case (rd_state)
      rd_idle: begin
        if (start) begin
          rd_next_state = rd_almost_full ? rd_fetch_key : rd_fetch;
        end
      end
      rd_fetch_key: begin
        if (!rd_almost_full) begin
          rd_next_state = rd_fetch;
        end
      end
      rd_fetch: begin
        if (credits >= DEPTH) begin
          rd_next_state = rd_wait;
        end
        else if (src_issue && ((rd_count + 1'b1) == num_lines)) begin
          rd_next_state = rd_finish;
        end
      end
      rd_wait: begin
        if (credits < DEPTH) begin
          rd_next_state = rd_fetch;
        end
      end
      rd_finish: begin
        if (blocks.valid && blocks.last) begin
          rd_next_state = rd_idle;
        end
      end
      default: rd_next_state = rd_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state     <= rd_idle;
      rd_req_valid <= 1'b0;
      rd_count     <= '0;
      in_flight    <= '0;
      key_valid    <= 1'b0;
      push         <= 1'b0;
      split_active <= 1'b0;
      split_idx    <= '0;
      split_count  <= '0;
      blocks.valid <= 1'b0;
    end
    else begin
      rd_state     <= rd_next_state;
      rd_req_valid <= key_issue || src_issue;
      in_flight    <= in_flight + CREDIT_BITS'(src_issue) - CREDIT_BITS'(push);
      // the first response of a job is the key and never enters the FIFO.
      push         <= rd_rsp_valid && key_valid;
      if (src_issue) begin
        rd_count <= rd_count + 1'b1;
      end
      if (rd_rsp_valid && !key_valid) begin
        key_valid <= 1'b1;
      end
      if (pop) begin
        blocks.valid <= 1'b1;
        split_active <= 1'b1;
        split_idx    <= 2'd1;
      end
      else if (split_active) begin
        blocks.valid <= 1'b1;
        split_idx    <= split_idx + 1'b1;
        if (split_idx == 2'd3) begin
          split_active <= 1'b0;
          split_count  <= split_count + 1'b1;
        end
      end
      else begin
        blocks.valid <= 1'b0;
      end
      if ((rd_state == rd_idle) && start) begin
        rd_count    <= '0;
        key_valid   <= 1'b0;
        split_count <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (key_issue) begin
      rd_req_addr <= key_addr;
    end
    else if (src_issue) begin
      rd_req_addr <= src_addr + rd_count;
    end
    if (rd_rsp_valid && !key_valid) begin
      key <= rd_rsp_data[BLOCK_BITS-1:0];
    end
    if (rd_rsp_valid) begin
      push_line <= rd_rsp_data;
    end
    if (pop) begin
      line_hold    <= pop_line;
      blocks.block <= pop_line[BLOCK_BITS-1:0];
      blocks.index <= 2'd0;
      blocks.last  <= 1'b0;
    end
    else if (split_active) begin
      blocks.block <= line_hold[split_idx * BLOCK_BITS +: BLOCK_BITS];
      blocks.index <= split_idx;
      blocks.last  <= (split_idx == 2'd3) && (split_count == (num_lines - 1'b1));
    end
  end

  // lines held in the FIFO plus reads still in flight never outgrow the FIFO.
  a_credit_bound : assert property (@(posedge clk) disable iff (reset)
    (credits <= DEPTH) && (fifo_not_full || (in_flight == '0)));

  // source reads wait until the key has come back.
  a_key_first : assert property (@(posedge clk) disable iff (reset)
    ((rd_state == rd_fetch) && !key_valid) |=> !rd_req_valid);

endmodule : read_requestor

`default_nettype wire

// File: aes_requestor/write_gatherer.sv
// Write gatherer, which packs blocks into lines, writes them out and posts the completion flag.
`timescale 1ns/1ps
`default_nettype none

module write_gatherer
  import aes_stream_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   start,
  input  wire t_addr                  dst_addr,
  input  wire t_addr                  dsm_addr,
  input  wire logic [$bits(t_addr)-1:0] num_lines,
  block_stream_if.sink                blocks,
  output logic                        wr_req_valid,
  output t_addr                       wr_req_addr,
  output t_line                       wr_req_data,
  input  wire logic                   wr_almost_full,
  input  wire logic                   wr_rsp_valid,
  output logic                        done
);

  localparam int BLOCK_BITS = $bits(t_block);

  t_wr_state wr_state;

  t_line pack_line;
  t_line pack_next;
  t_line pend_line;

  logic pack_full;
  logic pend_full;
  logic pend_free;
  logic line_end;
  logic line_issue;
  logic status_issue;
  logic [$bits(t_addr)-1:0] wr_offset;
  logic [$bits(t_addr)-1:0] rsp_count;

  assign line_issue   = (wr_state == wr_write) && !wr_almost_full;
  assign status_issue = (wr_state == wr_status) && !wr_almost_full;
  assign line_end     = blocks.valid && (blocks.index == 2'd3);
  assign pend_free    = !pend_full || line_issue;
  assign blocks.stall = pend_full;

  always_comb begin
    pack_next = pack_line;
    pack_next[blocks.index * BLOCK_BITS +: BLOCK_BITS] = blocks.block;
  end

  always_ff @(posedge clk) begin
    if (blocks.valid) begin
      pack_line <= pack_next;
    end
    if (line_end && pend_free) begin
      pend_line <= pack_next;
    end
    else if (pack_full && line_issue) begin
      pend_line <= pack_line;
    end
    if (line_issue) begin
      wr_req_addr <= dst_addr + wr_offset;
      wr_req_data <= pend_line;
    end
    else if (status_issue) begin
      wr_req_addr <= dsm_addr;
      wr_req_data <= t_line'(1);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state     <= wr_idle;
      pack_full    <= 1'b0;
      pend_full    <= 1'b0;
      wr_req_valid <= 1'b0;
      wr_offset    <= '0;
      rsp_count    <= '0;
      done         <= 1'b0;
    end
    else begin
      wr_req_valid <= line_issue || status_issue;
      if (wr_rsp_valid) begin
        rsp_count <= rsp_count + 1'b1;
      end
      // a finished line waits in the pack buffer while the pending line is blocked.
      if (line_end && !pend_free) begin
        pack_full <= 1'b1;
      end
      else if (pack_full && line_issue) begin
        pack_full <= 1'b0;
      end
      if (line_end && pend_free) begin
        pend_full <= 1'b1;
      end
      else if (line_issue) begin
        pend_full <= pack_full;
      end
      case (wr_state)
        wr_idle: begin
          if (start) begin
            wr_state  <= wr_collect;
            done      <= 1'b0;
            wr_offset <= '0;
            rsp_count <= '0;
          end
        end
        wr_collect: begin
          if (wr_offset == num_lines) begin
            wr_state <= wr_drain;
          end
          else if (pend_full) begin
            wr_state <= wr_write;
          end
        end
        wr_write: begin
          if (!wr_almost_full) begin
            wr_offset <= wr_offset + 1'b1;
            wr_state  <= wr_collect;
          end
        end
        wr_drain: begin
          if (rsp_count == num_lines) begin
            wr_state <= wr_status;
          end
        end
        wr_status: begin
          if (!wr_almost_full) begin
            wr_state <= wr_done;
          end
        end
        wr_done: begin
          done     <= 1'b1;
          wr_state <= wr_idle;
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // the stall level must stop the decoder before both line buffers are taken.
  a_no_block_loss : assert property (@(posedge clk) disable iff (reset)
    blocks.valid |-> !(pack_full && pend_full));

  // only the final block of the job's final line carries last.
  a_last_block : assert property (@(posedge clk) disable iff (reset)
    blocks.valid |->
      (blocks.last == (line_end &&
                       ((wr_offset + pend_full + pack_full) == (num_lines - 1'b1)))));

endmodule : write_gatherer

`default_nettype wire

// File: aes_stream_top.f
+incdir+common
common/aes_stream_pkg.sv
common/block_stream_if.sv
aes_requestor/line_fifo.sv
aes_requestor/read_requestor.sv
design/add_round_key_stage.sv
aes_requestor/write_gatherer.sv
design/aes_stream_top.sv
verification/host_memory_model.sv
verification/aes_stream_tb.sv

// File: common/aes_stream_config.svh
// AES stream engine configuration with the line, block, address and FIFO sizes.
`ifndef AES_STREAM_CONFIG_SVH
`define AES_STREAM_CONFIG_SVH

// one host memory line, as read from or written to the memory port.
`define AES_LINE_BITS 512

// width of one cipher block, which is also the key width.
`define AES_BLOCK_BITS 128

// line address width on the host port.
`define AES_ADDR_BITS 32

// depth of the line FIFO, and so the number of source reads that may be outstanding.
// any power of two of 4 or more works.
`define AES_FIFO_DEPTH 16

`endif

// File: common/aes_stream_pkg.sv
// AES stream package with the payload types and the FSM state encodings.
`default_nettype none

package aes_stream_pkg;

  // one memory line holds four blocks.
  typedef logic [511:0] t_line;

  typedef logic [127:0] t_block;

  typedef logic [31:0] t_addr;

  typedef enum logic [2:0] {
    rd_idle,
    rd_fetch_key,
    rd_fetch,
    rd_wait,
    rd_finish
  } t_rd_state;

  typedef enum logic [2:0] {
    wr_idle,
    wr_collect,
    wr_write,
    wr_drain,
    wr_status,
    wr_done
  } t_wr_state;

endpackage : aes_stream_pkg

`default_nettype wire

// File: common/block_stream_if.sv
// Block stream interface carrying 128-bit blocks of a line, with a stall level back.
`timescale 1ns/1ps
`default_nettype none

interface block_stream_if
  import aes_stream_pkg::*;
();

  logic   valid;
  t_block block;
  logic [1:0] index;
  logic   last;
  logic   stall;

  // a new line may only begin while stall is low, then runs four cycles.
  modport source (
    output valid, block, index, last,
    input  stall
  );

  modport sink (
    input  valid, block, index, last,
    output stall
  );

endinterface : block_stream_if

`default_nettype wire

// File: design/add_round_key_stage.sv
// AddRoundKey stage, a one-cycle register that XORs every block with the key.
`timescale 1ns/1ps
`default_nettype none

module add_round_key_stage
  import aes_stream_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire t_block  key,
  input  wire logic    key_valid,
  block_stream_if.sink   blocks_in,
  block_stream_if.source blocks_out
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      blocks_out.valid <= 1'b0;
    end
    else begin
      blocks_out.valid <= blocks_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (blocks_in.valid) begin
      blocks_out.block <= blocks_in.block ^ key;
      blocks_out.index <= blocks_in.index;
      blocks_out.last  <= blocks_in.last;
    end
  end

  // the stage never holds a block, so back-pressure passes through unchanged.
  assign blocks_in.stall = blocks_out.stall;

  a_key_ready : assert property (@(posedge clk) disable iff (reset)
    blocks_in.valid |-> key_valid);

endmodule : add_round_key_stage

`default_nettype wire

// File: design/aes_stream_top.sv
// AES stream engine top level connecting decode, AddRoundKey and result stages to the host ports.
`timescale 1ns/1ps
`default_nettype none
`include "aes_stream_config.svh"

module aes_stream_top
  import aes_stream_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      start,
  input  wire t_addr                     key_addr,
  input  wire t_addr                     src_addr,
  input  wire t_addr                     dst_addr,
  input  wire t_addr                     dsm_addr,
  input  wire logic [`AES_ADDR_BITS-1:0] num_lines,
  output logic                           rd_req_valid,
  output t_addr                          rd_req_addr,
  input  wire logic                      rd_almost_full,
  input  wire logic                      rd_rsp_valid,
  input  wire t_line                     rd_rsp_data,
  output logic                           wr_req_valid,
  output t_addr                          wr_req_addr,
  output t_line                          wr_req_data,
  input  wire logic                      wr_almost_full,
  input  wire logic                      wr_rsp_valid,
  output logic                           done
);

  t_block key;
  logic   key_valid;

  block_stream_if decode_to_execute ();
  block_stream_if execute_to_result ();

  read_requestor i_read_requestor (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .key_addr       (key_addr),
    .src_addr       (src_addr),
    .num_lines      (num_lines),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .rd_almost_full (rd_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .key            (key),
    .key_valid      (key_valid),
    .blocks         (decode_to_execute.source)
  );

  add_round_key_stage i_add_round_key_stage (
    .clk        (clk),
    .reset      (reset),
    .key        (key),
    .key_valid  (key_valid),
    .blocks_in  (decode_to_execute.sink),
    .blocks_out (execute_to_result.source)
  );

  write_gatherer i_write_gatherer (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .dst_addr       (dst_addr),
    .dsm_addr       (dsm_addr),
    .num_lines      (num_lines),
    .blocks         (execute_to_result.sink),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_req_data    (wr_req_data),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid),
    .done           (done)
  );

endmodule : aes_stream_top

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aes_stream_tb \
  -f aes_stream_top.f -o aes_stream_sim \
  && ./obj_dir/aes_stream_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// File: verification/aes_stream_tb.sv
// Testbench for the AES stream engine with a random host memory and a line-level model.
`timescale 1ns/1ps
`default_nettype none
`include "aes_stream_config.svh"

module aes_stream_tb
  import aes_stream_pkg::*;
();

  localparam t_addr KEY_BASE = 32'h1000_0000;
  localparam t_addr SRC_BASE = 32'h2000_0000;
  localparam t_addr DST_BASE = 32'h3000_0000;
  localparam t_addr DSM_BASE = 32'h4000_0000;
  localparam int    DEPTH    = `AES_FIFO_DEPTH;
  localparam int    TIMEOUT  = 20000;
  localparam int    JOBS     = 5;

  logic       clk = 1'b0;
  logic       reset;
  logic       start;
  t_addr      key_addr;
  t_addr      src_addr;
  t_addr      dst_addr;
  t_addr      dsm_addr;
  t_addr      num_lines;
  logic [6:0] pressure;
  logic       rd_req_valid;
  t_addr      rd_req_addr;
  logic       rd_almost_full;
  logic       rd_rsp_valid;
  t_line      rd_rsp_data;
  logic       wr_req_valid;
  t_addr      wr_req_addr;
  t_line      wr_req_data;
  logic       wr_almost_full;
  logic       wr_rsp_valid;
  logic       done;

  // line counts above the FIFO depth force the credit limit.
  // the last two jobs run under heavy pressure.
  int         job_lines [JOBS] = '{1, 4, 40, 40, 4};
  logic [6:0] job_pressure [JOBS] = '{10, 30, 10, 75, 75};

  int    errors = 0;
  int    checks = 0;
  int    cur_job;
  t_addr cur_key;
  t_addr cur_src;
  t_addr cur_dst;
  t_addr cur_dsm;
  t_addr cur_lines;
  logic  job_active = 1'b0;
  int    job_rsps;
  int    job_reads;
  int    dst_writes;
  int    status_writes;
  logic  done_seen;
  bit    dst_hits [t_addr];
  int    rd_reqs = 0;
  int    rd_rsps = 0;
  int    wr_reqs = 0;
  int    wr_rsps = 0;
  logic  rd_af_prev = 1'b0;
  logic  wr_af_prev = 1'b0;

  always #4 clk = ~clk;

  aes_stream_top i_dut (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .key_addr       (key_addr),
    .src_addr       (src_addr),
    .dst_addr       (dst_addr),
    .dsm_addr       (dsm_addr),
    .num_lines      (num_lines),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .rd_almost_full (rd_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_req_data    (wr_req_data),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid),
    .done           (done)
  );

  host_memory_model #(
    .KEY_BASE  (KEY_BASE),
    .KEY_LINES (8),
    .SRC_BASE  (SRC_BASE),
    .SRC_LINES (128)
  ) i_mem (
    .clk            (clk),
    .reset          (reset),
    .pressure       (pressure),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .rd_almost_full (rd_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_req_data    (wr_req_data),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid)
  );

  task automatic check_value(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // each 128-bit block of the source line is XORed with the key in place.
  function automatic t_line expected_line(input t_line src_line, input t_block key_block);
    t_line result;
    for (int j = 0; j < 4; j++) begin
      result[j*128 +: 128] = src_line[j*128 +: 128] ^ key_block;
    end
    return result;
  endfunction

  always @(posedge clk) begin : monitor
    t_addr offset;
    if (!reset) begin
      if (rd_req_valid && rd_af_prev) begin
        report_failure("read request raised after a cycle with read almost-full high");
      end
      if (wr_req_valid && wr_af_prev) begin
        report_failure("write request raised after a cycle with write almost-full high");
      end
      rd_af_prev = rd_almost_full;
      wr_af_prev = wr_almost_full;
      if (rd_req_valid) begin
        rd_reqs++;
        // the key line is read first, then the source lines in order.
        check_value($sformatf("job %0d read %0d address", cur_job, job_reads),
                    (job_reads == 0) ? cur_key : cur_src + t_addr'(job_reads - 1),
                    rd_req_addr);
        job_reads++;
      end
      if (rd_rsp_valid) begin
        rd_rsps++;
      end
      if ((rd_reqs - rd_rsps) > DEPTH) begin
        report_failure("more reads in flight than the line FIFO can hold");
      end
      if (wr_rsp_valid) begin
        wr_rsps++;
        job_rsps++;
      end
      if (wr_req_valid) begin
        wr_reqs++;
        offset = wr_req_addr - cur_dst;
        if (job_active && (wr_req_addr == cur_dsm)) begin
          check_value($sformatf("job %0d status data", cur_job), 1, wr_req_data);
          check_value($sformatf("job %0d responses before status", cur_job), cur_lines,
                      job_rsps);
          status_writes++;
        end
        else if (job_active && (offset < cur_lines)) begin
          check_value($sformatf("job %0d line %0d", cur_job, offset),
                      expected_line(i_mem.mem[cur_src + offset], i_mem.mem[cur_key][127:0]),
                      wr_req_data);
          if (dst_hits.exists(offset)) begin
            report_failure("a destination line was written twice");
          end
          dst_hits[offset] = 1'b1;
          dst_writes++;
        end
        else begin
          report_failure("write outside the destination range and the status address");
        end
      end
      if (job_active && done) begin
        if (status_writes == 0) begin
          report_failure("done rose before the status write");
        end
        done_seen = 1'b1;
      end
    end
  end

  initial begin : stimulus
    bit    timed_out;
    int    wait_cycles;
    t_addr src_next;
    timed_out = 1'b0;
    src_next  = '0;
    reset     = 1'b1;
    start     = 1'b0;
    key_addr  = '0;
    src_addr  = '0;
    dst_addr  = '0;
    dsm_addr  = '0;
    num_lines = '0;
    pressure  = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("done after reset", 0, done);
    for (int job = 0; (job < JOBS) && !timed_out; job++) begin
      cur_job       = job;
      cur_lines     = t_addr'(job_lines[job]);
      cur_key       = KEY_BASE + t_addr'(job);
      cur_src       = SRC_BASE + src_next;
      cur_dst       = DST_BASE + t_addr'(job * 64);
      cur_dsm       = DSM_BASE + t_addr'(job);
      src_next      = src_next + cur_lines;
      job_rsps      = 0;
      job_reads     = 0;
      dst_writes    = 0;
      status_writes = 0;
      done_seen     = 1'b0;
      dst_hits.delete();
      pressure      = job_pressure[job];
      key_addr      = cur_key;
      src_addr      = cur_src;
      dst_addr      = cur_dst;
      dsm_addr      = cur_dsm;
      num_lines     = cur_lines;
      start         = 1'b1;
      @(negedge clk);
      start      = 1'b0;
      job_active = 1'b1;
      wait_cycles = 0;
      while (!done && (wait_cycles < TIMEOUT)) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (!done) begin
        report_failure($sformatf("job %0d did not raise done in time", job));
        timed_out = 1'b1;
      end
      else begin
        // the status write response must land before the next start clears the count.
        wait_cycles = 0;
        do begin
          @(negedge clk);
          wait_cycles++;
        end while ((wr_rsps != wr_reqs) && (wait_cycles < TIMEOUT));
        if (wr_rsps != wr_reqs) begin
          report_failure($sformatf("job %0d write responses never drained", job));
          timed_out = 1'b1;
        end
        check_value($sformatf("job %0d reads", job), cur_lines + 1, job_reads);
        check_value($sformatf("job %0d destination writes", job), cur_lines, dst_writes);
        check_value($sformatf("job %0d status writes", job), 1, status_writes);
        check_value($sformatf("job %0d done seen", job), 1, done_seen);
      end
      job_active = 1'b0;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end
    else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : aes_stream_tb

`default_nettype wire

// File: verification/host_memory_model.sv
// Host memory model answering reads in order after random latencies, with random almost-full.
`timescale 1ns/1ps
`default_nettype none

module host_memory_model
  import aes_stream_pkg::*;
#(
  parameter t_addr KEY_BASE  = 32'h1000_0000,
  parameter int    KEY_LINES = 8,
  parameter t_addr SRC_BASE  = 32'h2000_0000,
  parameter int    SRC_LINES = 128
)
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic [6:0] pressure,
  input  wire logic       rd_req_valid,
  input  wire t_addr      rd_req_addr,
  output logic            rd_almost_full,
  output logic            rd_rsp_valid,
  output t_line           rd_rsp_data,
  input  wire logic       wr_req_valid,
  input  wire t_addr      wr_req_addr,
  input  wire t_line      wr_req_data,
  output logic            wr_almost_full,
  output logic            wr_rsp_valid
);

  integer seed = 32'h1523adf6;

  // sparse line storage, which also keeps every write the engine makes.
  t_line mem [t_addr];

  t_addr       rd_addr_q [$];
  int unsigned rd_due_q [$];
  int unsigned wr_due_q [$];
  int unsigned cycle;
  int unsigned rd_last_due;
  int unsigned wr_last_due;

  function automatic int unsigned random_below(input int unsigned span);
    return $unsigned($random(seed)) % span;
  endfunction

  initial begin : respond
    t_line       line;
    t_addr       addr;
    int unsigned due;
    rd_almost_full = 1'b0;
    rd_rsp_valid   = 1'b0;
    rd_rsp_data    = '0;
    wr_almost_full = 1'b0;
    wr_rsp_valid   = 1'b0;
    cycle          = 0;
    rd_last_due    = 0;
    wr_last_due    = 0;
    for (int n = 0; n < KEY_LINES + SRC_LINES; n++) begin
      for (int w = 0; w < 16; w++) begin
        line[w*32 +: 32] = $random(seed);
      end
      addr = (n < KEY_LINES) ? KEY_BASE + 32'(n) : SRC_BASE + 32'(n - KEY_LINES);
      mem[addr] = line;
    end
    forever begin
      @(posedge clk);
      if (reset) begin
        rd_addr_q.delete();
        rd_due_q.delete();
        wr_due_q.delete();
      end
      else begin
        // responses keep request order, so a due cycle never falls before the previous one.
        if (rd_req_valid) begin
          due = cycle + 2 + random_below(8);
          if (due <= rd_last_due) begin
            due = rd_last_due + 1;
          end
          rd_last_due = due;
          rd_addr_q.push_back(rd_req_addr);
          rd_due_q.push_back(due);
        end
        if (wr_req_valid) begin
          mem[wr_req_addr] = wr_req_data;
          due = cycle + 2 + random_below(8);
          if (due <= wr_last_due) begin
            due = wr_last_due + 1;
          end
          wr_last_due = due;
          wr_due_q.push_back(due);
        end
      end
      cycle++;
      @(negedge clk);
      rd_rsp_valid   = 1'b0;
      wr_rsp_valid   = 1'b0;
      rd_almost_full = 1'b0;
      wr_almost_full = 1'b0;
      if (!reset) begin
        if ((rd_due_q.size() != 0) && (rd_due_q[0] <= cycle)) begin
          addr = rd_addr_q.pop_front();
          void'(rd_due_q.pop_front());
          rd_rsp_valid = 1'b1;
          rd_rsp_data  = mem.exists(addr) ? mem[addr] : '0;
        end
        if ((wr_due_q.size() != 0) && (wr_due_q[0] <= cycle)) begin
          void'(wr_due_q.pop_front());
          wr_rsp_valid = 1'b1;
        end
        rd_almost_full = (random_below(100) < pressure);
        wr_almost_full = (random_below(100) < pressure);
      end
    end
  end

endmodule : host_memory_model

`default_nettype wire
